/* sim.f */
hw/netConfigPkg.sv
hw/netCtrlPkg.sv
hw/startDebounce.sv
hw/padInterface.sv
hw/netController.sv
hw/globalBuffer.sv
hw/poolCore.sv
hw/netTop.sv
testbench/tbClock.sv
testbench/netTop_properties.sv
testbench/tbTop.sv

/* run.sh */
#!/bin/sh
# Build and run the pooling testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tbTop -f sim.f -o tbSim

result=$(./obj_dir/tbSim)
echo "$result"
echo "$result" | grep -qx "Simulation passed"

/* testbench/net_stim.txt */
// Header per test: word count, K, random stall flag (hex)
// Then the data words, four per line; a count of 0 ends the list
10 4 0
0123456789abcdef fedcba9876543210 80807f7f01010000 00ff00ff00ff00ff
1122334455667788 8877665544332211 ff000000000000ff 7f7f7f7f80808080
0000000000000000 0000000000000001 0000000000000000 0000000000000000
a5a5a5a55a5a5a5a 5a5a5a5aa5a5a5a5 c3c3c3c33c3c3c3c 0f0f0f0ff0f0f0f0
8 1 0
deadbeefcafef00d 0123456789abcdef 0000000000000000 ffffffffffffffff
1020304050607080 8070605040302010 00000000000000ff ff00000000000000
c 2 1
0102030405060708 0807060504030201 9900aa00bb00cc00 00dd00ee00ff0011
7fffffff80000000 800000007fffffff 1111111111111111 2222222222222222
f0e0d0c0b0a09080 0f1e2d3c4b5a6978 3333333333333333 0000000000000000
0 0 0

/* testbench/tbTop.sv */
// Pooling accelerator testbench
`timescale 1ns/1ns

module tbTop;
    import netConfigPkg::*;

    localparam int clkPeriod = 4;
    localparam int stimSize  = 256;
    localparam int hsTimeout = 200;

    logic   clk;
    logic   rst;
    logic   startPulse;
    wordT   inDat;
    logic   inDatVld;
    logic   inDatRdy;
    wordT   outDat;
    logic   outDatVld;
    logic   outDatLast;
    logic   outDatRdy;
    logic   datOe;
    logic   netFnh;

    wordT   stim [stimSize];
    wordT   expQ [$];
    int     stimWords;
    int     errCount;
    int     testCount;
    bit     stimLoaded;
    integer seed = 32'h687f;

    tbClock #(.period(clkPeriod)) u_clock (.clk(clk), .rst(rst));

    netTop #(.debounceCycles(8)) u_dut (
        .clk        (clk),
        .rst        (rst),
        .startPulse (startPulse),
        .inDat      (inDat),
        .inDatVld   (inDatVld),
        .inDatRdy   (inDatRdy),
        .outDat     (outDat),
        .outDatVld  (outDatVld),
        .outDatLast (outDatLast),
        .outDatRdy  (outDatRdy),
        .datOe      (datOe),
        .netFnh     (netFnh)
    );

    // ==================================================
    // Helpers
    // ==================================================
    function automatic wordT byteMax(input wordT a, input wordT b);
        wordT r;
        for (int i = 0; i < 8; i++) begin
            r[i*8 +: 8] = (a[i*8 +: 8] > b[i*8 +: 8]) ? a[i*8 +: 8] : b[i*8 +: 8];
        end
        return r;
    endfunction

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic pressButton(input int cycles);
        @(posedge clk);
        #1 startPulse = 1'b1;
        repeat (cycles) @(posedge clk);
        #1 startPulse = 1'b0;
    endtask

    // Called just after a rising edge, returns just after the transfer edge
    task automatic sendWord(input wordT w);
        int waited;
        waited   = 0;
        inDat    = w;
        inDatVld = 1'b1;
        @(negedge clk);
        while (!inDatRdy && waited < hsTimeout) begin
            waited++;
            @(negedge clk);
        end
        if (!inDatRdy) begin
            $display("Timeout: input word %h was never accepted", w);
            errCount++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic collectOutputs(input int nOut, input bit stall);
        int          got;
        int          idle;
        int          tail;
        int          fnhSeen;
        wordT        exp;
        logic [31:0] rnd;
        got     = 0;
        idle    = 0;
        tail    = 0;
        fnhSeen = 0;
        while (tail < 6 && idle < hsTimeout) begin
            @(posedge clk);
            #1;
            rnd       = $random(seed);
            outDatRdy = stall ? rnd[0] : 1'b1;
            @(negedge clk);
            if (netFnh) begin
                fnhSeen++;
                if (got < nOut) begin
                    $display("netFnh pulsed before the final output handshake");
                    errCount++;
                end
            end
            if (outDatLast && !outDatVld) begin
                $display("outDatLast high without outDatVld at t=%0t", $time);
                errCount++;
            end
            if (outDatVld && outDatRdy) begin
                if (got >= nOut) begin
                    $display("Unexpected extra output word %h", outDat);
                    errCount++;
                end else begin
                    exp = expQ.pop_front();
                    if (outDat !== exp) begin
                        $display("FAIL t=%0t outDat: got %h, expected %h", $time, outDat, exp);
                        errCount++;
                    end
                    checkBit("outDatLast", outDatLast, got == nOut - 1);
                    checkBit("datOe", datOe, 1'b1);
                end
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            if (got >= nOut) begin
                tail++;
            end
        end
        outDatRdy = 1'b1;
        if (got < nOut) begin
            $display("Only %0d of %0d output words arrived", got, nOut);
            errCount++;
        end
        if (fnhSeen != 1) begin
            $display("netFnh pulsed %0d times instead of once", fnhSeen);
            errCount++;
        end
    endtask

    // ==================================================
    // Watchdog
    // ==================================================
    initial begin
        wait (stimLoaded);
        #(stimWords * 400 * clkPeriod);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        int   p;
        int   count;
        int   k;
        int   errBefore;
        bit   stall;
        wordT cfgWord;
        wordT acc;
        startPulse = 1'b0;
        inDat      = '0;
        inDatVld   = 1'b0;
        outDatRdy  = 1'b0;
        errCount   = 0;
        testCount  = 0;
        $readmemh("testbench/net_stim.txt", stim);
        p = 0;
        while (p < stimSize - 3 && stim[p] != '0) begin
            stimWords += 3 + int'(stim[p][6:0]);
            p += 3 + int'(stim[p][6:0]);
        end
        stimLoaded = 1'b1;

        // Outputs quiet after reset
        wait (rst === 1'b0);
        @(negedge clk);
        errBefore = errCount;
        checkBit("inDatRdy", inDatRdy, 1'b0);
        checkBit("outDatVld", outDatVld, 1'b0);
        checkBit("outDatLast", outDatLast, 1'b0);
        checkBit("datOe", datOe, 1'b0);
        checkBit("netFnh", netFnh, 1'b0);
        testCount++;
        $display("test %0d (reset values): %0d errors", testCount, errCount - errBefore);

        // Short glitch on the button must not start a run
        errBefore = errCount;
        pressButton(3);
        repeat (40) begin
            @(negedge clk);
            checkBit("inDatRdy", inDatRdy, 1'b0);
        end
        testCount++;
        $display("test %0d (button glitch): %0d errors", testCount, errCount - errBefore);

        p = 0;
        while (p < stimSize - 3 && stim[p] != '0) begin
            errBefore = errCount;
            count     = int'(stim[p][6:0]);
            k         = int'(stim[p + 1][3:0]);
            stall     = stim[p + 2][0];
            cfgWord   = '0;
            cfgWord[6:0]  = stim[p][6:0];
            cfgWord[11:8] = stim[p + 1][3:0];

            // Reference model takes the byte-wise max of each group of K
            expQ.delete();
            for (int g = 0; g + k <= count && k > 0; g += k) begin
                acc = stim[p + 3 + g];
                for (int j = 1; j < k; j++) begin
                    acc = byteMax(acc, stim[p + 3 + g + j]);
                end
                expQ.push_back(acc);
            end

            pressButton(24);
            sendWord(cfgWord);
            for (int i = 0; i < count; i++) begin
                sendWord(stim[p + 3 + i]);
            end
            inDatVld = 1'b0;
            collectOutputs(expQ.size(), stall);

            testCount++;
            $display("test %0d (%0d words, K %0d, stall %0d): %0d errors",
                     testCount, count, k, stall, errCount - errBefore);
            p += 3 + count;
        end

        $display("tests run: %0d, failed checks: %0d", testCount, errCount);
        if (errCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* testbench/netTop_properties.sv */
// Top-level handshake assertions
`timescale 1ns/1ns

module netTopProperties (
    input logic               clk,
    input logic               rst,
    input netConfigPkg::wordT outDat,
    input logic               outDatVld,
    input logic               outDatLast,
    input logic               outDatRdy,
    input logic               loadEn,
    input logic               datOe,
    input logic               netFnh
);

    // Stalled output word stays put
    stallHold: assert property (@(posedge clk) disable iff (rst)
        outDatVld && !outDatRdy |=> outDatVld && $stable(outDat))
        else $error("output word changed or dropped during a stall");

    // Pad drive window and load window never overlap
    padDirection: assert property (@(posedge clk) disable iff (rst)
        !(datOe && loadEn))
        else $error("datOe high while the controller is loading");

    // Finish pulse follows the last handshake and lasts one cycle
    finishPulse: assert property (@(posedge clk) disable iff (rst)
        netFnh |-> $past(outDatVld && outDatRdy && outDatLast) && !$past(netFnh))
        else $error("netFnh not a single pulse after the final handshake");

endmodule

bind netTop netTopProperties u_props (
    .clk        (clk),
    .rst        (rst),
    .outDat     (outDat),
    .outDatVld  (outDatVld),
    .outDatLast (outDatLast),
    .outDatRdy  (outDatRdy),
    .loadEn     (loadEn),
    .datOe      (datOe),
    .netFnh     (netFnh)
);

/* testbench/tbClock.sv */
// Testbench clock and reset
`timescale 1ns/1ns

module tbClock #(
    parameter int period = 4
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset held over two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* hw/netTop.sv */
// Point-cloud pooling top
`timescale 1ns/1ns

module netTop #(
    parameter int debounceCycles = 1000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               startPulse,
    input  netConfigPkg::wordT inDat,
    input  logic               inDatVld,
    output logic               inDatRdy,
    output netConfigPkg::wordT outDat,
    output logic               outDatVld,
    output logic               outDatLast,
    input  logic               outDatRdy,
    output logic               datOe,
    output logic               netFnh
);
    import netConfigPkg::*;

    logic startStrobe;
    logic loadEn;
    logic sendMode;
    logic inStrobe;
    wordT inWord;
    logic outFree;
    logic lastWord;
    logic wrEn;
    addrT wrAddr;
    wordT wrDat;
    logic rdEn;
    addrT rdAddr;
    wordT rdDat;
    logic rdVld;
    logic grpFirst;
    logic grpLast;
    wordT resDat;
    logic resVld;

    // ==================================================
    // Start button
    // ==================================================
    startDebounce #(
        .debounceCycles (debounceCycles)
    ) u_startDebounce (
        .clk         (clk),
        .rst         (rst),
        .button      (startPulse),
        .startStrobe (startStrobe)
    );

    // ==================================================
    // Pad side
    // ==================================================
    padInterface u_padInterface (
        .clk        (clk),
        .rst        (rst),
        .sendMode   (sendMode),
        .loadEn     (loadEn),
        .inDat      (inDat),
        .inDatVld   (inDatVld),
        .inDatRdy   (inDatRdy),
        .inWord     (inWord),
        .inStrobe   (inStrobe),
        .rdDat      (rdDat),
        .rdVld      (rdVld),
        .lastWord   (lastWord),
        .outFree    (outFree),
        .outDat     (outDat),
        .outDatVld  (outDatVld),
        .outDatLast (outDatLast),
        .outDatRdy  (outDatRdy),
        .datOe      (datOe)
    );

    // ==================================================
    // Control, buffer and pooling
    // ==================================================
    netController u_netController (
        .clk         (clk),
        .rst         (rst),
        .startStrobe (startStrobe),
        .inWord      (inWord),
        .inStrobe    (inStrobe),
        .loadEn      (loadEn),
        .sendMode    (sendMode),
        .outFree     (outFree),
        .lastWord    (lastWord),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrDat       (wrDat),
        .rdEn        (rdEn),
        .rdAddr      (rdAddr),
        .grpFirst    (grpFirst),
        .grpLast     (grpLast),
        .resDat      (resDat),
        .resVld      (resVld),
        .outDatVld   (outDatVld),
        .outDatRdy   (outDatRdy),
        .netFnh      (netFnh)
    );

    globalBuffer u_globalBuffer (
        .clk    (clk),
        .rst    (rst),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrDat  (wrDat),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdDat  (rdDat),
        .rdVld  (rdVld)
    );

    poolCore u_poolCore (
        .clk      (clk),
        .rst      (rst),
        .rdDat    (rdDat),
        .rdVld    (rdVld),
        .grpFirst (grpFirst),
        .grpLast  (grpLast),
        .resDat   (resDat),
        .resVld   (resVld)
    );

endmodule

/* hw/poolCore.sv */
// Byte-wise max pooling
`timescale 1ns/1ns

module poolCore (
    input  logic               clk,
    input  logic               rst,
    input  netConfigPkg::wordT rdDat,
    input  logic               rdVld,
    input  logic               grpFirst,
    input  logic               grpLast,
    output netConfigPkg::wordT resDat,
    output logic               resVld
);
    import netConfigPkg::*;

    logic firstD;
    logic lastD;
    wordT acc;
    wordT accNext;

    // Group flags delayed to meet the buffer data
    always_ff @(posedge clk) begin
        if (rst) begin
            firstD <= 1'b0;
            lastD  <= 1'b0;
            resVld <= 1'b0;
        end else begin
            firstD <= grpFirst;
            lastD  <= grpLast;
            resVld <= rdVld && lastD;
        end
    end

    // Unsigned max per byte lane
    always_comb begin
        for (int b = 0; b < wordBytes; b++) begin
            if (firstD || rdDat[b*actWidth +: actWidth] > acc[b*actWidth +: actWidth]) begin
                accNext[b*actWidth +: actWidth] = rdDat[b*actWidth +: actWidth];
            end else begin
                accNext[b*actWidth +: actWidth] = acc[b*actWidth +: actWidth];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdVld) begin
            acc <= accNext;
            if (lastD) begin
                resDat <= accNext;
            end
        end
    end

endmodule

/* hw/globalBuffer.sv */
// Global word buffer
`timescale 1ns/1ns

module globalBuffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               wrEn,
    input  netConfigPkg::addrT wrAddr,
    input  netConfigPkg::wordT wrDat,
    input  logic               rdEn,
    input  netConfigPkg::addrT rdAddr,
    output netConfigPkg::wordT rdDat,
    output logic               rdVld
);
    import netConfigPkg::*;

    wordT mem [bufDepth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrDat;
        end
        if (rdEn) begin
            rdDat <= mem[rdAddr];
        end
    end

    // Data valid one cycle after the read
    always_ff @(posedge clk) begin
        if (rst) begin
            rdVld <= 1'b0;
        end else begin
            rdVld <= rdEn;
        end
    end

endmodule

/* hw/netController.sv */
// Load, pool and send sequencing
`timescale 1ns/1ns

module netController (
    input  logic               clk,
    input  logic               rst,
    input  logic               startStrobe,
    input  netConfigPkg::wordT inWord,
    input  logic               inStrobe,
    output logic               loadEn,
    output logic               sendMode,
    input  logic               outFree,
    output logic               lastWord,
    output logic               wrEn,
    output netConfigPkg::addrT wrAddr,
    output netConfigPkg::wordT wrDat,
    output logic               rdEn,
    output netConfigPkg::addrT rdAddr,
    output logic               grpFirst,
    output logic               grpLast,
    input  netConfigPkg::wordT resDat,
    input  logic               resVld,
    input  logic               outDatVld,
    input  logic               outDatRdy,
    output logic               netFnh
);
    import netConfigPkg::*;
    import netCtrlPkg::*;

    ctrlStateT state;
    ctrlStateT stateNext;
    countT     wordCnt;
    countT     cfgCount;
    poolKT     kCfg;
    countT     xferCnt;
    poolKT     grpPos;
    countT     grpTotal;
    countT     resCnt;
    logic      inFlight;
    logic      lastIdx;
    logic      sendRd;
    logic      finalHs;

    assign cfgCount = inWord[cfgCountMsb:cfgCountLsb];
    assign lastIdx  = (xferCnt == wordCnt - 1'b1);
    assign sendRd   = (state == ctrlSend) && outFree && !inFlight && (xferCnt != grpTotal);
    // Final word sits alone in the output register once no read is pending
    assign finalHs  = !inFlight && (xferCnt == grpTotal) && outDatVld && outDatRdy;

    // ==================================================
    // State machine
    // ==================================================
    always_comb begin
        stateNext = state;
        case (state)
            ctrlIdle:  if (startStrobe) stateNext = ctrlCfg;
            ctrlCfg:   if (inStrobe) stateNext = ctrlLoad;
            ctrlLoad:  if (inStrobe && lastIdx) stateNext = ctrlPool;
            ctrlPool:  if (lastIdx) stateNext = ctrlDrain;
            ctrlDrain: if (resVld && resCnt == grpTotal - 1'b1) stateNext = ctrlSend;
            ctrlSend:  if (finalHs) stateNext = ctrlDone;
            ctrlDone:  stateNext = ctrlIdle;
            default:   stateNext = ctrlIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ctrlIdle;
            wordCnt  <= '0;
            kCfg     <= '0;
            xferCnt  <= '0;
            grpPos   <= '0;
            grpTotal <= '0;
            resCnt   <= '0;
            inFlight <= 1'b0;
        end else begin
            state    <= stateNext;
            inFlight <= sendRd;
            if (resVld) begin
                resCnt <= resCnt + 1'b1;
            end
            case (state)
                ctrlIdle: begin
                    xferCnt  <= '0;
                    grpPos   <= '0;
                    grpTotal <= '0;
                    resCnt   <= '0;
                end
                ctrlCfg: if (inStrobe) begin
                    // Clamp oversized loads to the input region
                    wordCnt <= (cfgCount > countT'(maxWords)) ? countT'(maxWords) : cfgCount;
                    kCfg    <= inWord[cfgKMsb:cfgKLsb];
                end
                ctrlLoad: if (inStrobe) begin
                    xferCnt <= lastIdx ? '0 : xferCnt + 1'b1;
                end
                ctrlPool: begin
                    xferCnt <= lastIdx ? '0 : xferCnt + 1'b1;
                    grpPos  <= grpLast ? '0 : grpPos + 1'b1;
                    if (grpLast) begin
                        grpTotal <= grpTotal + 1'b1;
                    end
                end
                ctrlSend: if (sendRd) begin
                    xferCnt <= xferCnt + 1'b1;
                end
                default: ;
            endcase
        end
    end

    // ==================================================
    // Outputs
    // ==================================================
    assign loadEn   = (state == ctrlCfg) || (state == ctrlLoad);
    // Taken from the next state so the registered datOe tracks the send state
    assign sendMode = (stateNext == ctrlSend);
    assign netFnh   = (state == ctrlDone);
    assign lastWord = inFlight && (xferCnt == grpTotal);

    assign grpFirst = (state == ctrlPool) && (grpPos == '0);
    assign grpLast  = (state == ctrlPool) && (grpPos == kCfg - 1'b1);

    assign rdEn   = (state == ctrlPool) || sendRd;
    assign rdAddr = (state == ctrlPool) ? inBase + xferCnt[5:0] : outBase + xferCnt[5:0];

    // Load words and pool results share the write port
    assign wrEn   = (state == ctrlLoad) ? inStrobe : resVld;
    assign wrAddr = (state == ctrlLoad) ? inBase + xferCnt[5:0] : outBase + resCnt[5:0];
    assign wrDat  = (state == ctrlLoad) ? inWord : resDat;

endmodule

/* hw/padInterface.sv */
// Pad direction and output register
`timescale 1ns/1ns

module padInterface (
    input  logic               clk,
    input  logic               rst,
    input  logic               sendMode,
    input  logic               loadEn,
    input  netConfigPkg::wordT inDat,
    input  logic               inDatVld,
    output logic               inDatRdy,
    output netConfigPkg::wordT inWord,
    output logic               inStrobe,
    input  netConfigPkg::wordT rdDat,
    input  logic               rdVld,
    input  logic               lastWord,
    output logic               outFree,
    output netConfigPkg::wordT outDat,
    output logic               outDatVld,
    output logic               outDatLast,
    input  logic               outDatRdy,
    output logic               datOe
);
    logic outLoad;

    // Buffer reads only reach the pad while it drives out
    assign outLoad = rdVld && datOe;

    always_ff @(posedge clk) begin
        if (rst) begin
            datOe      <= 1'b0;
            outDatVld  <= 1'b0;
            outDatLast <= 1'b0;
        end else begin
            datOe <= sendMode;
            if (outLoad) begin
                outDatVld  <= 1'b1;
                outDatLast <= lastWord;
            end else if (outDatRdy) begin
                outDatVld  <= 1'b0;
                outDatLast <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (outLoad) begin
            outDat <= rdDat;
        end
    end

    assign outFree  = !outDatVld || outDatRdy;
    assign inDatRdy = loadEn && !datOe;
    assign inStrobe = inDatVld && inDatRdy;
    assign inWord   = inDat;

endmodule

/* hw/startDebounce.sv */
// Start button debounce
`timescale 1ns/1ns

module startDebounce #(
    parameter int debounceCycles = 1000
) (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic startStrobe
);
    localparam int cntWidth = $clog2(debounceCycles + 1);

    logic                btnSync;
    logic [cntWidth-1:0] stableCnt;
    logic                debLevel;
    logic                debLevelD;

    always_ff @(posedge clk) begin
        if (rst) begin
            btnSync   <= 1'b0;
            stableCnt <= '0;
            debLevel  <= 1'b0;
            debLevelD <= 1'b0;
        end else begin
            btnSync   <= button;
            debLevelD <= debLevel;
            // Count only while the input disagrees with the settled level
            if (btnSync == debLevel) begin
                stableCnt <= '0;
            end else if (stableCnt == cntWidth'(debounceCycles - 1)) begin
                stableCnt <= '0;
                debLevel  <= btnSync;
            end else begin
                stableCnt <= stableCnt + 1'b1;
            end
        end
    end

    // Release of the button starts the run
    assign startStrobe = !debLevel && debLevelD;

endmodule

/* hw/netCtrlPkg.sv */
// Controller states and config word

package netCtrlPkg;

    typedef enum logic [2:0] {
        ctrlIdle,
        ctrlCfg,
        ctrlLoad,
        ctrlPool,
        ctrlDrain,
        ctrlSend,
        ctrlDone
    } ctrlStateT;

    // Config word fields
    localparam int cfgCountLsb = 0;
    localparam int cfgCountMsb = 6;
    localparam int cfgKLsb     = 8;
    localparam int cfgKMsb     = 11;

endpackage

/* hw/netConfigPkg.sv */
// Data format and buffer layout

package netConfigPkg;

    // ==================================================
    // Word format
    // ==================================================
    localparam int actWidth  = 8;
    localparam int wordBytes = 8;

    typedef logic [actWidth*wordBytes-1:0] wordT;

    // ==================================================
    // Buffer layout
    // ==================================================
    localparam int bufDepth = 64;
    localparam int maxWords = 32;

    typedef logic [$clog2(bufDepth)-1:0] addrT;
    typedef logic [6:0]                  countT;
    typedef logic [3:0]                  poolKT;

    // Input words at the bottom, pooled results in the upper half
    localparam addrT inBase  = 6'd0;
    localparam addrT outBase = 6'd32;

endpackage
